/* src/asg_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// shared widths, register map and bus/config structs for the signal
// generator; every design file refers to these through asg_pkg:: names
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package asg_pkg;

  // datapath widths
  localparam int dwo = 14;         // sample width
  localparam int cwm = 10;         // pointer integer part, 1024-entry table
  localparam int cwf = 16;         // pointer fraction part
  localparam int pw  = cwm + cwf;  // full fixed-point pointer

  localparam int buf_sel_bit = 16;  // address bit that selects the table
  localparam int reg_ow      = 8;   // decoded register offset width

  // register map
  localparam logic [reg_ow-1:0] reg_ctl  = 8'h00;  // write only, [0] rst [1] sw trigger
  localparam logic [reg_ow-1:0] reg_trg  = 8'h04;  // trigger select, burst enable above
  localparam logic [reg_ow-1:0] reg_size = 8'h08;
  localparam logic [reg_ow-1:0] reg_offs = 8'h0C;
  localparam logic [reg_ow-1:0] reg_step = 8'h10;
  localparam logic [reg_ow-1:0] reg_ncyc = 8'h18;
  localparam logic [reg_ow-1:0] reg_rnum = 8'h1C;
  localparam logic [reg_ow-1:0] reg_rdly = 8'h20;

  typedef struct packed {
    logic        wen;
    logic        ren;
    logic [31:0] addr;
    logic [31:0] wdata;
  } asg_bus_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        ack;
    logic        err;
  } asg_bus_rsp_t;

  // bus-side table port
  typedef struct packed {
    logic                  ena;
    logic                  wen;
    logic [cwm-1:0]        addr;
    logic signed [dwo-1:0] wdata;
  } asg_buf_req_t;

  typedef struct packed {
    logic [pw-1:0] size;  // table length, fixed point
    logic [pw-1:0] offs;  // start phase
    logic [pw-1:0] step;  // pointer increment
    logic          brst;  // burst mode
    logic [15:0]   ncyc;  // table cycles per repetition
    logic [15:0]   rnum;  // repetitions per burst
    logic [31:0]   rdly;  // idle cycles between repetitions
  } asg_cfg_t;

  typedef struct packed {
    logic rst;
    logic trg;
  } asg_ctl_t;

endpackage

`default_nettype wire

/* src/asg_regs.sv */
////////////////////////////////////////////////////////////////////////////
// system bus slave of the generator: config registers, table access
// forwarding, acknowledge sequencing and trigger select / edge detect
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module asg_regs #(
  parameter int unsigned twa = 4  // number of external trigger lines
) (
  input  logic                          clk,
  input  logic                          rstn,
  input  asg_pkg::asg_bus_req_t         bus_req,
  output asg_pkg::asg_bus_rsp_t         bus_rsp,
  output asg_pkg::asg_buf_req_t         buf_req,
  input  logic signed [asg_pkg::dwo-1:0] buf_rdata,
  input  logic [twa-1:0]                trg_ext,
  output asg_pkg::asg_cfg_t             cfg,
  output asg_pkg::asg_ctl_t             ctl
);

  localparam int tws = (twa > 1) ? $clog2(twa) : 1;  // trigger select width

  logic [asg_pkg::reg_ow-1:0] offs;
  logic                       reg_acc;   // register region access
  logic                       buf_acc;   // table region access
  logic                       ctl_wr;
  logic [tws-1:0]             tsel;
  logic [1:0]                 rd_dly;    // table read in flight
  logic [1:0]                 trg_q;     // selected line, current and previous
  logic [31:0]                reg_rdata;
  logic                       reg_miss;  // unmapped offset

  assign offs    = bus_req.addr[asg_pkg::reg_ow-1:0];
  assign reg_acc = (bus_req.wen | bus_req.ren) & ~bus_req.addr[asg_pkg::buf_sel_bit];
  assign buf_acc = (bus_req.wen | bus_req.ren) &  bus_req.addr[asg_pkg::buf_sel_bit];
  assign ctl_wr  = reg_acc & bus_req.wen & (offs == asg_pkg::reg_ctl);

  ////////////////////////////////////////////////////////////////////////////
  // configuration registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      cfg  <= '0;
      tsel <= '0;
    end else if (reg_acc && bus_req.wen) begin
      case (offs)
        asg_pkg::reg_trg:  {cfg.brst, tsel} <= bus_req.wdata[tws:0];
        asg_pkg::reg_size: cfg.size <= bus_req.wdata[asg_pkg::pw-1:0];
        asg_pkg::reg_offs: cfg.offs <= bus_req.wdata[asg_pkg::pw-1:0];
        asg_pkg::reg_step: cfg.step <= bus_req.wdata[asg_pkg::pw-1:0];
        asg_pkg::reg_ncyc: cfg.ncyc <= bus_req.wdata[15:0];
        asg_pkg::reg_rnum: cfg.rnum <= bus_req.wdata[15:0];
        asg_pkg::reg_rdly: cfg.rdly <= bus_req.wdata;
        default: ;  // ctl and holes hold nothing
      endcase
    end
  end

  // read mux, zero filled above each field
  always_comb begin
    reg_rdata = '0;
    reg_miss  = 1'b0;
    case (offs)
      asg_pkg::reg_ctl:  reg_rdata = '0;  // write only
      asg_pkg::reg_trg:  reg_rdata = {{(31-tws){1'b0}}, cfg.brst, tsel};
      asg_pkg::reg_size: reg_rdata = {{(32-asg_pkg::pw){1'b0}}, cfg.size};
      asg_pkg::reg_offs: reg_rdata = {{(32-asg_pkg::pw){1'b0}}, cfg.offs};
      asg_pkg::reg_step: reg_rdata = {{(32-asg_pkg::pw){1'b0}}, cfg.step};
      asg_pkg::reg_ncyc: reg_rdata = {16'h0, cfg.ncyc};
      asg_pkg::reg_rnum: reg_rdata = {16'h0, cfg.rnum};
      asg_pkg::reg_rdly: reg_rdata = cfg.rdly;
      default:           reg_miss  = 1'b1;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // table request and bus response
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      buf_req <= '0;
      rd_dly  <= '0;
      bus_rsp <= '0;
    end else begin
      buf_req.ena   <= buf_acc;
      buf_req.wen   <= buf_acc & bus_req.wen;
      buf_req.addr  <= bus_req.addr[2 +: asg_pkg::cwm];     // word index
      buf_req.wdata <= bus_req.wdata[asg_pkg::dwo-1:0];
      rd_dly        <= {rd_dly[0], buf_acc & bus_req.ren};  // req reg, then ram
      // writes and register reads answer at once, table reads after rd_dly
      bus_rsp.ack   <= reg_acc | (buf_acc & bus_req.wen) | rd_dly[1];
      bus_rsp.err   <= reg_acc & bus_req.ren & reg_miss;
      if (rd_dly[1]) begin
        bus_rsp.rdata <= {{(32-asg_pkg::dwo){1'b0}}, buf_rdata};
      end else if (reg_acc && bus_req.ren) begin
        bus_rsp.rdata <= reg_rdata;
      end else begin
        bus_rsp.rdata <= '0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // trigger: select, register, rising edge, OR software bit
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      trg_q <= '0;
      ctl   <= '0;
    end else begin
      trg_q   <= {trg_q[0], trg_ext[tsel]};
      ctl.rst <= ctl_wr & bus_req.wdata[0];
      ctl.trg <= (ctl_wr & bus_req.wdata[1]) | (trg_q[0] & ~trg_q[1]);
    end
  end

endmodule

`default_nettype wire

/* src/asg_buf.sv */
////////////////////////////////////////////////////////////////////////////
// waveform table: dual-port synchronous ram, bus port read/write,
// engine port read only with a held output while its enable is low
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module asg_buf (
  input  logic                           clk,
  input  asg_pkg::asg_buf_req_t          buf_req,
  output logic signed [asg_pkg::dwo-1:0] buf_rdata,
  input  logic                           rd_en,
  input  logic [asg_pkg::cwm-1:0]        rd_addr,
  output logic signed [asg_pkg::dwo-1:0] rd_data
);

  logic signed [asg_pkg::dwo-1:0] mem [0:2**asg_pkg::cwm-1];

  // bus port, read before write
  always_ff @(posedge clk) begin
    if (buf_req.ena) begin
      if (buf_req.wen) begin
        mem[buf_req.addr] <= buf_req.wdata;
      end
      buf_rdata <= mem[buf_req.addr];
    end
  end

  // engine port
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];  // holds otherwise, feeds the stream
    end
  end

endmodule

`default_nettype wire

/* src/asg_engine.sv */
////////////////////////////////////////////////////////////////////////////
// read-pointer engine: steps a fixed-point pointer through the table,
// continuous or burst, and drives the valid/ready sample stream
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module asg_engine (
  input  logic                           clk,
  input  logic                           rstn,
  input  asg_pkg::asg_cfg_t              cfg,
  input  asg_pkg::asg_ctl_t              ctl,
  output logic                           rd_en,
  output logic [asg_pkg::cwm-1:0]        rd_addr,
  input  logic signed [asg_pkg::dwo-1:0] rd_data,
  output logic signed [asg_pkg::dwo-1:0] sto_dat,
  output logic                           sto_vld,
  input  logic                           sto_rdy,
  output logic                           trg_out
);

  typedef enum logic [1:0] {
    st_idle,
    st_run,   // continuous wrap
    st_brst,  // inside a repetition
    st_dly    // gap between repetitions
  } state_t;

  state_t                    state;
  logic [asg_pkg::pw-1:0]    ptr;
  logic [asg_pkg::pw:0]      ptr_add;  // one spare bit for the compare
  logic [asg_pkg::pw:0]      ptr_sub;
  logic                      ptr_wrap;
  logic [asg_pkg::pw-1:0]    ptr_nxt;
  logic [15:0]               cyc_cnt;  // table cycles this repetition
  logic [15:0]               cyc_nxt;
  logic [15:0]               rep_cnt;  // repetitions done
  logic [15:0]               rep_nxt;
  logic [31:0]               dly_cnt;
  logic                      rep_end;

  ////////////////////////////////////////////////////////////////////////////
  // pointer arithmetic
  ////////////////////////////////////////////////////////////////////////////

  assign ptr_add  = {1'b0, ptr} + {1'b0, cfg.step};
  assign ptr_sub  = ptr_add - {1'b0, cfg.size};
  assign ptr_wrap = ptr_add >= {1'b0, cfg.size};  // one table cycle done
  assign ptr_nxt  = ptr_wrap ? ptr_sub[asg_pkg::pw-1:0] : ptr_add[asg_pkg::pw-1:0];
  assign cyc_nxt  = cyc_cnt + 16'd1;
  assign rep_nxt  = rep_cnt + 16'd1;

  // read only when the output register is free or being taken
  assign rd_en   = ((state == st_run) || (state == st_brst)) && (!sto_vld || sto_rdy);
  assign rd_addr = ptr[asg_pkg::pw-1:asg_pkg::cwf];  // integer part

  // last read of a repetition
  assign rep_end = (state == st_brst) && rd_en && ptr_wrap && (cyc_nxt >= cfg.ncyc);

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state   <= st_idle;
      ptr     <= '0;
      cyc_cnt <= '0;
      rep_cnt <= '0;
      dly_cnt <= '0;
      trg_out <= 1'b0;
    end else begin
      trg_out <= 1'b0;
      if (ctl.rst) begin
        state <= st_idle;
      end else begin
        case (state)
          st_idle: begin
            if (ctl.trg) begin
              state   <= cfg.brst ? st_brst : st_run;
              ptr     <= cfg.offs;
              cyc_cnt <= '0;
              rep_cnt <= '0;
              trg_out <= 1'b1;  // repetition start
            end
          end
          st_run: begin
            if (rd_en) ptr <= ptr_nxt;
          end
          st_brst: begin
            if (rd_en) begin
              ptr <= ptr_nxt;
              if (ptr_wrap) cyc_cnt <= cyc_nxt;
            end
            if (rep_end) begin
              if (rep_nxt >= cfg.rnum) begin
                state <= st_idle;  // burst complete
              end else begin
                state   <= st_dly;
                dly_cnt <= cfg.rdly;
                rep_cnt <= rep_nxt;
              end
            end
          end
          st_dly: begin
            // count only once the last sample has left
            if (!sto_vld) begin
              if (dly_cnt <= 32'd1) begin
                state   <= st_brst;
                ptr     <= cfg.offs;
                cyc_cnt <= '0;
                trg_out <= 1'b1;
              end else begin
                dly_cnt <= dly_cnt - 32'd1;
              end
            end
          end
          default: state <= st_idle;
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stream output
  ////////////////////////////////////////////////////////////////////////////

  assign sto_dat = rd_data;  // ram port register is the stream register

  always_ff @(posedge clk) begin
    if (!rstn || ctl.rst) begin
      sto_vld <= 1'b0;  // pending sample dropped
    end else if (rd_en) begin
      sto_vld <= 1'b1;
    end else if (sto_rdy) begin
      sto_vld <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* src/asg_top.sv */
////////////////////////////////////////////////////////////////////////////
// single-channel arbitrary signal generator: bus registers, waveform
// table and read-pointer engine; twa sets the external trigger count
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module asg_top #(
  parameter int unsigned twa = 4  // external trigger lines
) (
  input  logic                           clk,
  input  logic                           rstn,
  // system bus
  input  asg_pkg::asg_bus_req_t          bus_req,
  output asg_pkg::asg_bus_rsp_t          bus_rsp,
  // triggers
  input  logic [twa-1:0]                 trg_ext,
  output logic                           trg_out,  // repetition start
  // sample stream to the dac
  output logic signed [asg_pkg::dwo-1:0] sto_dat,
  output logic                           sto_vld,
  input  logic                           sto_rdy
);

  asg_pkg::asg_buf_req_t          buf_req;
  logic signed [asg_pkg::dwo-1:0] buf_rdata;
  asg_pkg::asg_cfg_t              cfg;
  asg_pkg::asg_ctl_t              ctl;
  // engine side of the table
  logic                           rd_en;
  logic [asg_pkg::cwm-1:0]        rd_addr;
  logic signed [asg_pkg::dwo-1:0] rd_data;

  asg_regs #(
    .twa (twa)
  ) u_regs (
    .clk       (clk),
    .rstn      (rstn),
    .bus_req   (bus_req),
    .bus_rsp   (bus_rsp),
    .buf_req   (buf_req),
    .buf_rdata (buf_rdata),
    .trg_ext   (trg_ext),
    .cfg       (cfg),
    .ctl       (ctl)
  );

  asg_buf u_buf (
    .clk       (clk),
    .buf_req   (buf_req),
    .buf_rdata (buf_rdata),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

  asg_engine u_engine (
    .clk     (clk),
    .rstn    (rstn),
    .cfg     (cfg),
    .ctl     (ctl),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .sto_dat (sto_dat),
    .sto_vld (sto_vld),
    .sto_rdy (sto_rdy),
    .trg_out (trg_out)
  );

endmodule

`default_nettype wire

/* dv/asg_asserts.sv */
////////////////////////////////////////////////////////////////////////////
// protocol assertions for the signal generator top, attached by bind:
// stream hold under back-pressure, single-cycle ack, idle after reset
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module asg_asserts (
  input logic                           clk,
  input logic                           rstn,
  input logic                           ctl_rst,  // engine control reset pulse
  input logic                           ack,
  input logic                           sto_vld,
  input logic                           sto_rdy,
  input logic signed [asg_pkg::dwo-1:0] sto_dat
);

  int fail_cnt = 0;  // read by the testbench at the end

  // held sample may only be dropped by a control reset
  a_hold: assert property (@(posedge clk) disable iff (!rstn)
    sto_vld && !sto_rdy && !ctl_rst |=> sto_vld && $stable(sto_dat))
    else begin
      fail_cnt++;
      $error("stream valid or data changed while waiting for ready");
    end

  a_ack: assert property (@(posedge clk) disable iff (!rstn) ack |=> !ack)
    else begin
      fail_cnt++;
      $error("bus ack high on two consecutive cycles");
    end

  a_rst: assert property (@(posedge clk) (!rstn || ctl_rst) |=> !sto_vld)
    else begin
      fail_cnt++;
      $error("stream valid high in the cycle after a reset");
    end

endmodule

bind asg_top asg_asserts u_asserts (
  .clk     (clk),
  .rstn    (rstn),
  .ctl_rst (ctl.rst),
  .ack     (bus_rsp.ack),
  .sto_vld (sto_vld),
  .sto_rdy (sto_rdy),
  .sto_dat (sto_dat)
);

`default_nettype wire

/* dv/asg_tb.sv */
////////////////////////////////////////////////////////////////////////////
// testbench for the signal generator top: register and table access over
// the bus, then continuous, burst and trigger runs with a sample checker
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module asg_tb;

  localparam int twa        = 4;
  localparam int tws        = $clog2(twa);  // trigger select width
  localparam int pw         = asg_pkg::pw;
  localparam int cwf        = asg_pkg::cwf;
  localparam int max_cycles = 20000;  // table fill ~2100, all runs well under 3000
  localparam logic [31:0] buf_base = 32'h0001_0000;

  logic                  clk = 1'b0;
  logic                  rstn;
  asg_pkg::asg_bus_req_t bus_req;
  asg_pkg::asg_bus_rsp_t bus_rsp;
  logic [twa-1:0]        trg_ext;
  logic                  trg_out;
  logic signed [13:0]    sto_dat;
  logic                  sto_vld;
  logic                  sto_rdy;

  integer        seed = 32'h294b_0f55;
  int            rnd;
  logic          rdy_rand = 1'b0;   // random back-pressure on
  logic [13:0]   tbl_model [0:1023];  // mirror of the table
  logic [pw-1:0] m_size;
  logic [pw-1:0] m_offs;
  logic [pw-1:0] m_step;
  logic [pw-1:0] exp_ptr;
  int            n_acc = 0;   // accepted samples
  int            n_trg = 0;   // trg_out pulses
  int            cycles = 0;
  string         cur_test = "reset";

  asg_top #(
    .twa (twa)
  ) uut (
    .clk     (clk),
    .rstn    (rstn),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .trg_ext (trg_ext),
    .trg_out (trg_out),
    .sto_dat (sto_dat),
    .sto_vld (sto_vld),
    .sto_rdy (sto_rdy)
  );

  always #2 clk = ~clk;  // 4 ns period

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [13:0] fill_value(input int i);
    int v;
    v = i * 37 + 5;
    return v[13:0];  // truncated to sample width
  endfunction

  // pointer advance, minus size once it reaches the table end
  function automatic logic [pw-1:0] next_ptr(input logic [pw-1:0] p, step, size);
    logic [pw:0] s;
    s = {1'b0, p} + {1'b0, step};
    if (s >= {1'b0, size}) s = s - {1'b0, size};
    return s[pw-1:0];
  endfunction

  // reads needed for ncyc table wraps from offs
  function automatic int reads_per_rep(input logic [pw-1:0] offs, step, size,
                                       input int ncyc);
    logic [pw:0] s;
    logic [pw-1:0] p;
    int n;
    int wraps;
    p = offs;
    n = 0;
    wraps = 0;
    while (wraps < ncyc) begin
      s = {1'b0, p} + {1'b0, step};
      if (s >= {1'b0, size}) begin
        wraps++;
        s = s - {1'b0, size};
      end
      p = s[pw-1:0];
      n++;
    end
    return n;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // reporting and bus tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic expect_eq(input string name, input logic [31:0] exp, act);
    assert (act === exp) else
      fail_run($sformatf("[FAIL] %s expected %0h actual %0h", name, exp, act));
  endtask

  task automatic bus_write(input logic [31:0] addr, data);
    @(posedge clk);
    #1;
    bus_req = '{wen: 1'b1, ren: 1'b0, addr: addr, wdata: data};
    @(posedge clk);
    #1;
    bus_req = '0;
    while (!bus_rsp.ack) begin
      @(posedge clk);
      #1;
    end
  endtask

  // lat counts cycles from the request edge to ack
  task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata,
                          output logic err, output int lat);
    @(posedge clk);
    #1;
    bus_req = '{wen: 1'b0, ren: 1'b1, addr: addr, wdata: 32'h0};
    @(posedge clk);
    #1;
    bus_req = '0;
    lat = 1;
    while (!bus_rsp.ack) begin
      @(posedge clk);
      #1;
      lat++;
    end
    rdata = bus_rsp.rdata;
    err   = bus_rsp.err;
  endtask

  task automatic wait_samples(input int n);
    int target;
    target = n_acc + n;
    while (n_acc < target) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic watch_idle(input int n);
    repeat (n) begin
      expect_eq({cur_test, " sto_vld idle"}, 32'd0, {31'd0, sto_vld});
      @(posedge clk);
      #1;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stream side: ready, compare, watchdog
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    #1;
    rnd     = $random(seed);
    sto_rdy = rdy_rand ? rnd[0] : 1'b1;
  end

  // negedge sees the values that transfer on the next rising edge
  always @(negedge clk) begin
    if (rstn) begin
      if (trg_out) begin
        exp_ptr = m_offs;  // every repetition restarts at offs
        n_trg++;
      end
      if (sto_vld && sto_rdy) begin
        expect_eq({cur_test, " sample"}, {18'd0, tbl_model[exp_ptr[pw-1:cwf]]},
                  {18'd0, sto_dat});
        exp_ptr = next_ptr(exp_ptr, m_step, m_size);
        n_acc++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    assert (cycles < max_cycles) else
      fail_run($sformatf("timeout: run did not finish within %0d cycles", max_cycles));
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] offs_l [0:6];
    logic [31:0] mask_l [0:6];
    logic [31:0] wv;
    logic [31:0] rd;
    logic        err;
    int          lat;
    int          idx;
    int          exp_cnt;
    int          acc0;
    int          trg0;

    rstn    = 1'b0;
    bus_req = '0;
    trg_ext = '0;
    sto_rdy = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    rstn = 1'b1;

    // 1: register read-back, masked to field width
    cur_test = "reg_readback";
    offs_l = '{asg_pkg::reg_trg, asg_pkg::reg_size, asg_pkg::reg_offs,
               asg_pkg::reg_step, asg_pkg::reg_ncyc, asg_pkg::reg_rnum,
               asg_pkg::reg_rdly};
    mask_l = '{(32'd1 << (tws + 1)) - 1, (32'd1 << pw) - 1, (32'd1 << pw) - 1,
               (32'd1 << pw) - 1, 32'h0000_ffff, 32'h0000_ffff, 32'hffff_ffff};
    for (int k = 0; k < 7; k++) begin
      wv = $random(seed);
      bus_write(offs_l[k], wv);
      bus_read(offs_l[k], rd, err, lat);
      expect_eq(cur_test, wv & mask_l[k], rd);
      expect_eq({cur_test, " err"}, 32'd0, {31'd0, err});
    end
    cur_test = "reg_unmapped";
    bus_read(32'h14, rd, err, lat);
    expect_eq({cur_test, " err"}, 32'd1, {31'd0, err});
    expect_eq({cur_test, " rdata"}, 32'd0, rd);

    // 2: fill whole table, spot-check read-back and latency
    cur_test = "buf_access";
    for (int i = 0; i < 1024; i++) begin
      tbl_model[i] = fill_value(i);
      bus_write(buf_base | (i << 2), {18'd0, tbl_model[i]});
    end
    for (int k = 0; k < 8; k++) begin
      idx = $random(seed) & 1023;
      bus_read(buf_base | (idx << 2), rd, err, lat);
      expect_eq(cur_test, {18'd0, tbl_model[idx]}, rd);
      expect_eq({cur_test, " latency"}, 32'd3, lat);
    end

    // 3: continuous, step 1.5, offset 17.25, table of 200
    cur_test = "continuous";
    m_size = {10'd200, 16'h0000};
    m_offs = {10'd17, 16'h4000};
    m_step = {10'd1, 16'h8000};
    bus_write(asg_pkg::reg_trg, 32'h0);
    bus_write(asg_pkg::reg_size, m_size);
    bus_write(asg_pkg::reg_offs, m_offs);
    bus_write(asg_pkg::reg_step, m_step);
    rdy_rand = 1'b1;
    bus_write(asg_pkg::reg_ctl, 32'h2);  // software trigger
    wait_samples(300);
    bus_write(asg_pkg::reg_ctl, 32'h1);
    repeat (3) @(posedge clk);
    #1;

    // 4: burst, 2 table cycles x 3 repetitions, gap of 5
    cur_test = "burst";
    m_size = {10'd40, 16'h0000};
    m_offs = {10'd3, 16'h8000};
    m_step = {10'd2, 16'h4000};
    exp_cnt = 3 * reads_per_rep(m_offs, m_step, m_size, 2);
    bus_write(asg_pkg::reg_size, m_size);
    bus_write(asg_pkg::reg_offs, m_offs);
    bus_write(asg_pkg::reg_step, m_step);
    bus_write(asg_pkg::reg_ncyc, 32'd2);
    bus_write(asg_pkg::reg_rnum, 32'd3);
    bus_write(asg_pkg::reg_rdly, 32'd5);
    bus_write(asg_pkg::reg_trg, 32'd1 << tws);  // brst, line 0
    acc0 = n_acc;
    trg0 = n_trg;
    bus_write(asg_pkg::reg_ctl, 32'h2);
    // third repetition start, then the end of its stream
    while (n_trg - trg0 < 3) begin
      @(posedge clk);
      #1;
    end
    while (!sto_vld) begin
      @(posedge clk);
      #1;
    end
    while (sto_vld) begin
      @(posedge clk);
      #1;
    end
    watch_idle(200);
    expect_eq({cur_test, " samples"}, exp_cnt, n_acc - acc0);
    expect_eq({cur_test, " trg_out"}, 32'd3, n_trg - trg0);

    // 5: line select, control reset, software restart
    cur_test = "trigger";
    bus_write(asg_pkg::reg_trg, 32'd1);  // continuous, line 1
    trg0 = n_trg;
    @(posedge clk);
    #1;
    trg_ext = 4'b0100;  // unselected line
    @(posedge clk);
    #1;
    trg_ext = '0;
    watch_idle(20);
    expect_eq({cur_test, " no start"}, trg0, n_trg);
    trg_ext = 4'b0010;
    @(posedge clk);
    #1;
    trg_ext = '0;
    wait_samples(20);
    expect_eq({cur_test, " line start"}, trg0 + 1, n_trg);
    bus_write(asg_pkg::reg_ctl, 32'h1);
    @(posedge clk);
    #1;
    watch_idle(50);
    bus_write(asg_pkg::reg_ctl, 32'h2);
    wait_samples(20);  // checker restarts its pointer at offs
    expect_eq({cur_test, " sw restart"}, trg0 + 2, n_trg);

    if (uut.u_asserts.fail_cnt == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      fail_run("concurrent assertions on the stream or bus reported errors");
    end
  end

endmodule

`default_nettype wire

/* files.f */
src/asg_pkg.sv
src/asg_regs.sv
src/asg_buf.sv
src/asg_engine.sv
src/asg_top.sv
dv/asg_asserts.sv
dv/asg_tb.sv
